// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP      = tb_axi_slave_port
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: include/axi_port_cfg.svh
// Build-time sizes for the AXI slave port stage
// Included by the channel word package and by the top level
`ifndef AXI_PORT_CFG_SVH
`define AXI_PORT_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Byte address toward the external slave
`define AXI_PORT_ADDR_W 16

// Data path width, strobe width follows as one bit per byte
`define AXI_PORT_DATA_W 32

// Transaction ID as seen by the slave
`define AXI_PORT_ID_W 4

////////////////////////////////////////////////////////////////////////////
// Buffering
////////////////////////////////////////////////////////////////////////////

// Requests the slave may hold open, sets the AW, AR and B FIFO depth
`define AXI_PORT_OSTD_NUM 4

// Beats per outstanding request
// W and R FIFOs hold OSTD_NUM times this many beats
`define AXI_PORT_OSTD_SIZE 4

`endif

// File: project.f
+incdir+include
source/axi_port_pkg.sv
source/axi_chan_fifo.sv
source/axi_slave_port.sv
verif/tb_axi_slave_port.sv

// File: source/axi_chan_fifo.sv
// Single-clock FIFO for one AXI channel, registered output, no fall-through
// Ready upstream is the inverse of o_full, valid downstream the inverse of o_empty
`default_nettype none

module axi_chan_fifo #(
    // Number of entries, power of 2 and at least 2
    parameter int DEPTH = 4,
    // Bits per entry
    parameter int WIDTH = 8
) (
    input  wire logic             i_aclk,
    input  wire logic             i_rst_n,
    input  wire logic             i_srst,
    // Write side
    input  wire logic             i_push,
    input  wire logic [WIDTH-1:0] i_data,
    output logic                  o_full,
    // Read side
    input  wire logic             i_pull,
    output logic                  o_empty,
    output logic      [WIDTH-1:0] o_data
);

    localparam int AW = axi_port_pkg::fifo_addr_w(DEPTH);
    localparam int PW = axi_port_pkg::fifo_ptr_w(DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // Declarations
    ////////////////////////////////////////////////////////////////////////////

    logic [WIDTH-1:0] mem [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] level;

    logic do_push;
    logic do_pull;

    ////////////////////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////////////////////

    // Same index, wrap bits differ
    assign o_full = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign o_empty = (wr_ptr == rd_ptr);

    assign level = wr_ptr - rd_ptr;

    // A full FIFO still takes a push when the head leaves in the same cycle
    assign do_pull = i_pull & ~o_empty;
    assign do_push = i_push & (~o_full | do_pull);

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_aclk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= i_data;
        end
    end

    // Head entry, becomes visible the cycle after it was written
    assign o_data = mem[rd_ptr[AW-1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_full_empty: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        !(o_full && o_empty)
    ) else $error("FIFO reports full and empty at once");

    // Wrap bit keeps the distance within one lap
    a_occupancy: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        level <= DEPTH
    ) else $error("FIFO holds %0d entries, depth is %0d", level, DEPTH);

endmodule

`default_nettype wire

// File: source/axi_port_pkg.sv
// Channel word layouts carried between the switch side and the slave port
// Also holds the FIFO pointer sizing helpers
`default_nettype none

`include "axi_port_cfg.svh"

package axi_port_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Channel words
    ////////////////////////////////////////////////////////////////////////////

    // Address request, shared by AW and AR
    typedef struct packed {
        logic [`AXI_PORT_ID_W-1:0]   id;
        logic [2:0]                  prot;
        logic [7:0]                  len;
        logic [`AXI_PORT_ADDR_W-1:0] addr;
    } aw_req_t;

    // Write beat with full strobe
    typedef struct packed {
        logic                          last;
        logic [`AXI_PORT_DATA_W/8-1:0] strb;
        logic [`AXI_PORT_DATA_W-1:0]   data;
    } w_beat_t;

    // Write response
    typedef struct packed {
        logic [`AXI_PORT_ID_W-1:0] id;
        logic [1:0]                resp;
    } b_resp_t;

    // Read beat, id sits in the low bits
    typedef struct packed {
        logic                        last;
        logic [1:0]                  resp;
        logic [`AXI_PORT_DATA_W-1:0] data;
        logic [`AXI_PORT_ID_W-1:0]   id;
    } r_beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // FIFO sizing
    ////////////////////////////////////////////////////////////////////////////

    // Index bits into the storage array
    function automatic int fifo_addr_w(input int depth);
        return (depth < 2) ? 1 : $clog2(depth);
    endfunction

    // Pointer bits, one wrap bit above the index
    function automatic int fifo_ptr_w(input int depth);
        return fifo_addr_w(depth) + 1;
    endfunction

endpackage

`default_nettype wire

// File: source/axi_slave_port.sv
// Buffered slave-side port of the AXI crossbar, one FIFO per channel
// Switch side moves channel structs, slave side uses flat restricted-AXI4 signals
`default_nettype none

`include "axi_port_cfg.svh"

module axi_slave_port (
    input  wire logic                            i_aclk,
    input  wire logic                            i_rst_n,
    input  wire logic                            i_srst,

    // Switch side, write address
    input  wire logic                            i_s_awvalid,
    output logic                                 o_s_awready,
    input  wire axi_port_pkg::aw_req_t           i_s_aw,
    // Switch side, write data
    input  wire logic                            i_s_wvalid,
    output logic                                 o_s_wready,
    input  wire axi_port_pkg::w_beat_t           i_s_w,
    // Switch side, write response
    output logic                                 o_s_bvalid,
    input  wire logic                            i_s_bready,
    output axi_port_pkg::b_resp_t                o_s_b,
    // Switch side, read address
    input  wire logic                            i_s_arvalid,
    output logic                                 o_s_arready,
    input  wire axi_port_pkg::aw_req_t           i_s_ar,
    // Switch side, read data
    output logic                                 o_s_rvalid,
    input  wire logic                            i_s_rready,
    output axi_port_pkg::r_beat_t                o_s_r,

    // Slave side, write address
    output logic                                 o_m_awvalid,
    input  wire logic                            i_m_awready,
    output logic      [`AXI_PORT_ADDR_W-1:0]     o_m_awaddr,
    output logic      [7:0]                      o_m_awlen,
    output logic      [2:0]                      o_m_awprot,
    output logic      [`AXI_PORT_ID_W-1:0]       o_m_awid,
    // Slave side, write data
    output logic                                 o_m_wvalid,
    input  wire logic                            i_m_wready,
    output logic                                 o_m_wlast,
    output logic      [`AXI_PORT_DATA_W-1:0]     o_m_wdata,
    output logic      [`AXI_PORT_DATA_W/8-1:0]   o_m_wstrb,
    // Slave side, write response
    input  wire logic                            i_m_bvalid,
    output logic                                 o_m_bready,
    input  wire logic [`AXI_PORT_ID_W-1:0]       i_m_bid,
    input  wire logic [1:0]                      i_m_bresp,
    // Slave side, read address
    output logic                                 o_m_arvalid,
    input  wire logic                            i_m_arready,
    output logic      [`AXI_PORT_ADDR_W-1:0]     o_m_araddr,
    output logic      [7:0]                      o_m_arlen,
    output logic      [2:0]                      o_m_arprot,
    output logic      [`AXI_PORT_ID_W-1:0]       o_m_arid,
    // Slave side, read data
    input  wire logic                            i_m_rvalid,
    output logic                                 o_m_rready,
    input  wire logic [`AXI_PORT_ID_W-1:0]       i_m_rid,
    input  wire logic [1:0]                      i_m_rresp,
    input  wire logic [`AXI_PORT_DATA_W-1:0]     i_m_rdata,
    input  wire logic                            i_m_rlast
);

    // One entry per outstanding request on AW, AR and B
    localparam int REQ_DEPTH  = `AXI_PORT_OSTD_NUM;
    // Every beat of every outstanding request on W and R
    localparam int BEAT_DEPTH = `AXI_PORT_OSTD_NUM * `AXI_PORT_OSTD_SIZE;

    ////////////////////////////////////////////////////////////////////////////
    // Declarations
    ////////////////////////////////////////////////////////////////////////////

    logic aw_full;
    logic aw_empty;
    logic w_full;
    logic w_empty;
    logic b_full;
    logic b_empty;
    logic ar_full;
    logic ar_empty;
    logic r_full;
    logic r_empty;

    axi_port_pkg::aw_req_t aw_q;
    axi_port_pkg::w_beat_t w_q;
    axi_port_pkg::b_resp_t b_d;
    axi_port_pkg::aw_req_t ar_q;
    axi_port_pkg::r_beat_t r_d;

    ////////////////////////////////////////////////////////////////////////////
    // Write address channel
    ////////////////////////////////////////////////////////////////////////////

    axi_chan_fifo #(
        .DEPTH (REQ_DEPTH),
        .WIDTH ($bits(axi_port_pkg::aw_req_t))
    ) u_aw_fifo (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_srst  (i_srst),
        .i_push  (i_s_awvalid & o_s_awready),
        .i_data  (i_s_aw),
        .o_full  (aw_full),
        .i_pull  (i_m_awready),
        .o_empty (aw_empty),
        .o_data  (aw_q)
    );

    assign o_s_awready = ~aw_full;
    assign o_m_awvalid = ~aw_empty;

    assign o_m_awid   = aw_q.id;
    assign o_m_awprot = aw_q.prot;
    assign o_m_awlen  = aw_q.len;
    assign o_m_awaddr = aw_q.addr;

    ////////////////////////////////////////////////////////////////////////////
    // Write data channel
    ////////////////////////////////////////////////////////////////////////////

    axi_chan_fifo #(
        .DEPTH (BEAT_DEPTH),
        .WIDTH ($bits(axi_port_pkg::w_beat_t))
    ) u_w_fifo (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_srst  (i_srst),
        .i_push  (i_s_wvalid & o_s_wready),
        .i_data  (i_s_w),
        .o_full  (w_full),
        .i_pull  (i_m_wready),
        .o_empty (w_empty),
        .o_data  (w_q)
    );

    assign o_s_wready = ~w_full;
    assign o_m_wvalid = ~w_empty;

    assign o_m_wlast = w_q.last;
    assign o_m_wstrb = w_q.strb;
    assign o_m_wdata = w_q.data;

    ////////////////////////////////////////////////////////////////////////////
    // Write response channel
    ////////////////////////////////////////////////////////////////////////////

    assign b_d.id   = i_m_bid;
    assign b_d.resp = i_m_bresp;

    axi_chan_fifo #(
        .DEPTH (REQ_DEPTH),
        .WIDTH ($bits(axi_port_pkg::b_resp_t))
    ) u_b_fifo (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_srst  (i_srst),
        .i_push  (i_m_bvalid & o_m_bready),
        .i_data  (b_d),
        .o_full  (b_full),
        .i_pull  (i_s_bready),
        .o_empty (b_empty),
        .o_data  (o_s_b)
    );

    assign o_m_bready = ~b_full;
    assign o_s_bvalid = ~b_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Read address channel
    ////////////////////////////////////////////////////////////////////////////

    axi_chan_fifo #(
        .DEPTH (REQ_DEPTH),
        .WIDTH ($bits(axi_port_pkg::aw_req_t))
    ) u_ar_fifo (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_srst  (i_srst),
        .i_push  (i_s_arvalid & o_s_arready),
        .i_data  (i_s_ar),
        .o_full  (ar_full),
        .i_pull  (i_m_arready),
        .o_empty (ar_empty),
        .o_data  (ar_q)
    );

    assign o_s_arready = ~ar_full;
    assign o_m_arvalid = ~ar_empty;

    assign o_m_arid   = ar_q.id;
    assign o_m_arprot = ar_q.prot;
    assign o_m_arlen  = ar_q.len;
    assign o_m_araddr = ar_q.addr;

    ////////////////////////////////////////////////////////////////////////////
    // Read data channel
    ////////////////////////////////////////////////////////////////////////////

    assign r_d.last = i_m_rlast;
    assign r_d.resp = i_m_rresp;
    assign r_d.data = i_m_rdata;
    assign r_d.id   = i_m_rid;

    axi_chan_fifo #(
        .DEPTH (BEAT_DEPTH),
        .WIDTH ($bits(axi_port_pkg::r_beat_t))
    ) u_r_fifo (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_srst  (i_srst),
        .i_push  (i_m_rvalid & o_m_rready),
        .i_data  (r_d),
        .o_full  (r_full),
        .i_pull  (i_s_rready),
        .o_empty (r_empty),
        .o_data  (o_s_r)
    );

    assign o_m_rready = ~r_full;
    assign o_s_rvalid = ~r_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Slave-side handshake checks
    ////////////////////////////////////////////////////////////////////////////

    // A stalled request must wait unchanged for the slave
    a_aw_hold: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        o_m_awvalid && !i_m_awready && !i_srst |=> o_m_awvalid && $stable(aw_q)
    ) else $error("AW request changed before the slave accepted it");

    a_w_hold: assert property (
        @(posedge i_aclk) disable iff (!i_rst_n)
        o_m_wvalid && !i_m_wready && !i_srst |=> o_m_wvalid && $stable(w_q)
    ) else $error("W beat changed before the slave accepted it");

endmodule

`default_nettype wire

// File: verif/axi_port_golden.txt
# phase channel word: one transfer per line, word in hex in the channel struct layout
# the word is the stimulus on the sending side and the expected value on the receiving side
2 aw 1A031000
2 aw 29100204
2 ar 3B070400
2 ar 04000010
3 w 0F11223344
3 w 0E55667788
3 w 0F89ABCDEF
3 w 1F0BADF00D
4 b 2C
4 b 11
4 r 0DEADBEEF3
4 r 4CAFEBABE5
5 aw 10010000
5 aw 18020040
5 aw 200300C0
5 aw 28040100
5 w 0F50000000
5 w 0F50000001
5 w 0F50000002
5 w 1F50000003
5 w 0350000004
5 w 0350000005
5 w 0350000006
5 w 1350000007
5 w 0C50000008
5 w 0C50000009
5 w 0C5000000A
5 w 1C5000000B
5 w 0F5000000C
5 w 0F5000000D
5 w 0F5000000E
5 w 1F5000000F
6 aw 7A0FFFF0
6 w 1FFFFFFFFF
6 b 3F
6 ar 55000010
6 r 7FFFFFFFFF

// File: verif/tb_axi_slave_port.sv
// Testbench for the buffered AXI slave port that replays the golden file through all five FIFOs
// Run it through the Makefile and read the error count and the verdict in the last lines
`default_nettype none

`include "axi_port_cfg.svh"

module tb_axi_slave_port;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    TRAFFIC_LIMIT = 400;
    localparam string GOLDEN        = "verif/axi_port_golden.txt";

    logic i_aclk;
    logic i_rst_n;
    logic i_srst;

    // DUT inputs
    logic i_s_awvalid, i_s_wvalid, i_s_arvalid, i_m_bvalid, i_m_rvalid;
    logic i_m_awready, i_m_wready, i_m_arready, i_s_bready, i_s_rready;
    axi_port_pkg::aw_req_t         i_s_aw;
    axi_port_pkg::aw_req_t         i_s_ar;
    axi_port_pkg::w_beat_t         i_s_w;
    logic [`AXI_PORT_ID_W-1:0]     i_m_bid;
    logic [`AXI_PORT_ID_W-1:0]     i_m_rid;
    logic [1:0]                    i_m_bresp;
    logic [1:0]                    i_m_rresp;
    logic [`AXI_PORT_DATA_W-1:0]   i_m_rdata;
    logic                          i_m_rlast;

    // DUT outputs
    logic o_s_awready, o_s_wready, o_s_arready, o_m_bready, o_m_rready;
    logic o_m_awvalid, o_m_wvalid, o_m_arvalid, o_s_bvalid, o_s_rvalid;
    axi_port_pkg::b_resp_t         o_s_b;
    axi_port_pkg::r_beat_t         o_s_r;
    logic [`AXI_PORT_ADDR_W-1:0]   o_m_awaddr;
    logic [`AXI_PORT_ADDR_W-1:0]   o_m_araddr;
    logic [7:0]                    o_m_awlen;
    logic [7:0]                    o_m_arlen;
    logic [2:0]                    o_m_awprot;
    logic [2:0]                    o_m_arprot;
    logic [`AXI_PORT_ID_W-1:0]     o_m_awid;
    logic [`AXI_PORT_ID_W-1:0]     o_m_arid;
    logic                          o_m_wlast;
    logic [`AXI_PORT_DATA_W-1:0]   o_m_wdata;
    logic [`AXI_PORT_DATA_W/8-1:0] o_m_wstrb;

    ////////////////////////////////////////////////////////////////////////////
    // Channel bundles indexed AW, W, B, AR, R from 0 to 4
    ////////////////////////////////////////////////////////////////////////////

    logic [4:0]  drv_valid;
    logic [63:0] drv_word [5];
    logic [4:0]  take;
    logic [4:0]  in_ready;
    logic [4:0]  out_valid;
    logic [63:0] out_word [5];

    // Words of the current phase in transfer order
    logic [63:0] words [5][32];
    int          count [5];
    int          sent [5];
    int          got [5];
    int          errors;
    int          timeouts;
    logic [31:0] lfsr;

    // Sending side of each channel
    assign i_s_awvalid = drv_valid[0];
    assign i_s_aw      = drv_word[0][30:0];
    assign i_s_wvalid  = drv_valid[1];
    assign i_s_w       = drv_word[1][36:0];
    assign i_m_bvalid  = drv_valid[2];
    assign i_m_bid     = drv_word[2][5:2];
    assign i_m_bresp   = drv_word[2][1:0];
    assign i_s_arvalid = drv_valid[3];
    assign i_s_ar      = drv_word[3][30:0];
    assign i_m_rvalid  = drv_valid[4];
    assign i_m_rlast   = drv_word[4][38];
    assign i_m_rresp   = drv_word[4][37:36];
    assign i_m_rdata   = drv_word[4][35:4];
    assign i_m_rid     = drv_word[4][3:0];

    // Receiving side of each channel
    assign i_m_awready = take[0];
    assign i_m_wready  = take[1];
    assign i_s_bready  = take[2];
    assign i_m_arready = take[3];
    assign i_s_rready  = take[4];

    assign in_ready  = {o_m_rready, o_s_arready, o_m_bready, o_s_wready, o_s_awready};
    assign out_valid = {o_s_rvalid, o_m_arvalid, o_s_bvalid, o_m_wvalid, o_m_awvalid};

    // Flat slave signals regrouped in the channel word layout
    assign out_word[0] = 64'({o_m_awid, o_m_awprot, o_m_awlen, o_m_awaddr});
    assign out_word[1] = 64'({o_m_wlast, o_m_wstrb, o_m_wdata});
    assign out_word[2] = 64'(o_s_b);
    assign out_word[3] = 64'({o_m_arid, o_m_arprot, o_m_arlen, o_m_araddr});
    assign out_word[4] = 64'(o_s_r);

    axi_slave_port i_axi_slave_port (.*);

    initial begin
        i_aclk = 1'b0;
        forever #50 i_aclk = ~i_aclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per random bit
    function automatic logic next_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic string chan_tag(input int c);
        case (c)
            0:       return "aw";
            1:       return "w";
            2:       return "b";
            3:       return "ar";
            default: return "r";
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] got_val,
                         input logic [63:0] exp_val);
        if (got_val !== exp_val) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got_val, exp_val);
        end
    endtask

    // Empty FIFOs show no valid and full readiness everywhere
    task automatic check_idle();
        check("out_valid", 64'(out_valid), 64'h00);
        check("in_ready", 64'(in_ready), 64'h1f);
    endtask

    task automatic load_phase(input int phase);
        int          fd;
        int          ph;
        int          n;
        int          c;
        string       line;
        string       tag;
        logic [63:0] word;
        foreach (count[k]) begin
            count[k] = 0;
            sent[k]  = 0;
            got[k]   = 0;
        end
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            errors++;
            $display("The golden file %s could not be opened", GOLDEN);
            return;
        end
        // Header lines fail the scan and drop out here
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%d %s %h", ph, tag, word);
            if (n == 3 && ph == phase) begin
                c = -1;
                for (int k = 0; k < 5; k++)
                    if (tag == chan_tag(k))
                        c = k;
                if (c < 0 || count[c] >= 32) begin
                    errors++;
                    $display("Golden line not usable: %s", line);
                end else begin
                    words[c][count[c]] = word;
                    count[c]++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Moves the phase words through every channel
    // Receivers hold off while stalled
    task automatic run_traffic(input bit stall);
        int cyc;
        bit busy;
        cyc  = 0;
        busy = 1'b1;
        while (busy && cyc < TRAFFIC_LIMIT) begin
            @(negedge i_aclk);
            cyc++;
            busy = 1'b0;
            for (int c = 0; c < 5; c++) begin
                drv_valid[c] = (sent[c] < count[c]);
                if (drv_valid[c]) begin
                    drv_word[c] = words[c][sent[c]];
                    if (in_ready[c])
                        sent[c]++;
                end
                take[c] = 1'b0;
                if (!stall && got[c] < count[c])
                    take[c] = next_bit();
                if (out_valid[c] && take[c]) begin
                    check($sformatf("out_word[%0d] (%s)", c, chan_tag(c)), out_word[c],
                          words[c][got[c]]);
                    got[c]++;
                end
                if (sent[c] < count[c] || (!stall && got[c] < count[c]))
                    busy = 1'b1;
            end
        end
        if (busy) begin
            timeouts++;
            $display("Timeout: channel traffic did not finish within %0d cycles", TRAFFIC_LIMIT);
        end
        // Last accepted beat leaves on the edge before this one
        @(negedge i_aclk);
        drv_valid = '0;
        take      = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        lfsr      = 32'he6326149;
        errors    = 0;
        timeouts  = 0;
        i_rst_n   = 1'b0;
        i_srst    = 1'b0;
        drv_valid = '0;
        take      = '0;
        foreach (drv_word[c])
            drv_word[c] = '0;
        repeat (16) @(negedge i_aclk);
        i_rst_n = 1'b1;
        @(negedge i_aclk);
        check_idle();

        // Requests, write beats, then responses and read beats
        for (int ph = 2; ph <= 4; ph++) begin
            load_phase(ph);
            run_traffic(1'b0);
        end

        // Fill AW and W against a stalled slave, then drain
        load_phase(5);
        run_traffic(1'b1);
        check("o_s_awready", 64'(o_s_awready), 64'h0);
        check("o_s_wready", 64'(o_s_wready), 64'h0);
        run_traffic(1'b0);

        // Queue one entry per channel and clear it
        load_phase(6);
        run_traffic(1'b1);
        check("out_valid", 64'(out_valid), 64'h1f);
        i_srst = 1'b1;
        @(negedge i_aclk);
        i_srst = 1'b0;
        check_idle();

        // A leftover entry would come out ahead of this fresh traffic
        for (int ph = 2; ph <= 4; ph++) begin
            load_phase(ph);
            run_traffic(1'b0);
        end

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
